// File: common/radio_pkg.sv
// --------------------
// radio sample format and stream constants
// shared by the capture, scaler and channel mux blocks
// one sample word is I in the upper half, Q in the lower half
// --------------------
package radio_pkg;

   // --------------------
   // stream geometry
   localparam int NUM_RADIOS      = 2;
   localparam int CHANS_PER_RADIO = 2;
   localparam int NUM_CHANNELS    = NUM_RADIOS * CHANS_PER_RADIO;

   // --------------------
   // sample format
   localparam int SAMPLE_W = 32;
   localparam int IQ_W     = 16;

   // baseband path
   localparam int SCALE_FRAC     = 15;  // scale is signed Q1.15
   localparam int BB_RADIO       = 0;   // radio feeding the tag path
   localparam int SCALER_LATENCY = 2;

   // one word seen either raw or as a signed I/Q pair
   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      struct packed {
         logic signed [IQ_W-1:0] i;
         logic signed [IQ_W-1:0] q;
      } iq;
   } iq_sample_u;

endpackage

// File: common/settings_pkg.sv
// --------------------
// settings bus and readback address map
// write addresses start at SR_DB_BASE, readback at RB_DB_BASE
// --------------------
package settings_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // --------------------
   // settings writes
   localparam logic [ADDR_W-1:0] SR_DB_BASE   = 8'd160;
   localparam logic [ADDR_W-1:0] SR_MISC_OUT0 = SR_DB_BASE;
   localparam logic [ADDR_W-1:0] SR_MISC_OUT1 = SR_DB_BASE + 8'd1;
   localparam logic [ADDR_W-1:0] SR_SCALE     = SR_DB_BASE + 8'd2;  // low 16 bits
   localparam logic [ADDR_W-1:0] SR_RUN_RX    = SR_DB_BASE + 8'd3;  // bit 0

   // --------------------
   // readback
   localparam logic [ADDR_W-1:0] RB_DB_BASE  = 8'd16;
   localparam logic [ADDR_W-1:0] RB_MISC_IN0 = RB_DB_BASE;
   localparam logic [ADDR_W-1:0] RB_MISC_IN1 = RB_DB_BASE + 8'd1;
   localparam logic [ADDR_W-1:0] RB_SCALE    = RB_DB_BASE + 8'd2;

endpackage

// File: logic/radio_rx_capture.sv
// --------------------
// input stage of the receive stream
// registers both radio sample words and their strobes once
// so every later stage works from flops on radio_clk
// --------------------
`timescale 1ns/1ps

module radio_rx_capture (
   input  logic                                   radio_clk,
   input  logic                                   i_rst_n,
   input  logic [radio_pkg::SAMPLE_W-1:0]         i_rx0,
   input  logic [radio_pkg::SAMPLE_W-1:0]         i_rx1,
   input  logic [radio_pkg::NUM_RADIOS-1:0]       i_rx_stb,
   output radio_pkg::iq_sample_u [radio_pkg::NUM_RADIOS-1:0] o_samples,
   output logic [radio_pkg::NUM_RADIOS-1:0]       o_stb
);

   // --------------------
   // sample words
   always_ff @(posedge radio_clk) begin
      o_samples[0].raw <= i_rx0;
      o_samples[1].raw <= i_rx1;
   end

   // strobes qualify the words downstream
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_stb <= '0;
      end else begin
         o_stb <= i_rx_stb;
      end
   end

endmodule

// File: db_settings/db_settings.sv
// --------------------
// daughterboard settings bank for the radio clock domain
// settings writes land in misc out, scale and run registers
// misc inputs are sampled every cycle for readback
// readback answers one cycle after i_rb_stb, unknown addresses read 0
// --------------------
`timescale 1ns/1ps

module db_settings (
   input  logic                              radio_clk,
   input  logic                              i_rst_n,
   // settings bus
   input  logic                              i_set_stb,
   input  logic [settings_pkg::ADDR_W-1:0]   i_set_addr,
   input  logic [settings_pkg::DATA_W-1:0]   i_set_data,
   // readback bus
   input  logic                              i_rb_stb,
   input  logic [settings_pkg::ADDR_W-1:0]   i_rb_addr,
   output logic                              o_rb_stb,
   output logic [settings_pkg::DATA_W-1:0]   o_rb_data,
   // radio misc pins
   input  logic [settings_pkg::DATA_W-1:0]   i_radio0_misc_in,
   input  logic [settings_pkg::DATA_W-1:0]   i_radio1_misc_in,
   output logic [settings_pkg::DATA_W-1:0]   o_radio0_misc_out,
   output logic [settings_pkg::DATA_W-1:0]   o_radio1_misc_out,
   // baseband control
   output logic [radio_pkg::IQ_W-1:0]        o_scale,
   output logic                              o_run_rx
);

   logic [settings_pkg::DATA_W-1:0] misc_in0_q;
   logic [settings_pkg::DATA_W-1:0] misc_in1_q;

   // --------------------
   // write decode
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_radio0_misc_out <= '0;
         o_radio1_misc_out <= '0;
         o_scale           <= '0;
         o_run_rx          <= 1'b0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            settings_pkg::SR_MISC_OUT0: o_radio0_misc_out <= i_set_data;
            settings_pkg::SR_MISC_OUT1: o_radio1_misc_out <= i_set_data;
            settings_pkg::SR_SCALE:     o_scale <= i_set_data[radio_pkg::IQ_W-1:0];
            settings_pkg::SR_RUN_RX:    o_run_rx <= i_set_data[0];
            default: ;  // not ours
         endcase
      end
   end

   // misc pins sampled every cycle
   always_ff @(posedge radio_clk) begin
      misc_in0_q <= i_radio0_misc_in;
      misc_in1_q <= i_radio1_misc_in;
   end

   // --------------------
   // readback
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_stb <= 1'b0;
      end else begin
         o_rb_stb <= i_rb_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) begin
         case (i_rb_addr)
            settings_pkg::RB_MISC_IN0: o_rb_data <= misc_in0_q;
            settings_pkg::RB_MISC_IN1: o_rb_data <= misc_in1_q;
            settings_pkg::RB_SCALE:
               o_rb_data <= {{(settings_pkg::DATA_W-radio_pkg::IQ_W){1'b0}}, o_scale};
            default:                   o_rb_data <= '0;
         endcase
      end
   end

endmodule

// File: tag_rx/tag_rx_scaler.sv
// --------------------
// tag baseband scaler
// stage 1 multiplies I and Q by the signed Q1.15 scale
// stage 2 shifts back by SCALE_FRAC and saturates to 16 bits
// accepts a new sample every cycle
// --------------------
`timescale 1ns/1ps

module tag_rx_scaler (
   input  logic                               radio_clk,
   input  logic                               i_rst_n,
   input  radio_pkg::iq_sample_u              i_sample,
   input  logic                               i_sample_stb,
   input  logic                               i_run_rx,
   input  logic signed [radio_pkg::IQ_W-1:0]  i_scale,
   output radio_pkg::iq_sample_u              o_bb_sample,
   output logic                               o_bb_valid
);

   logic signed [2*radio_pkg::IQ_W-1:0] prod_i;
   logic signed [2*radio_pkg::IQ_W-1:0] prod_q;
   logic                                prod_valid;

   // arithmetic shift then clamp to the component range
   function automatic logic signed [radio_pkg::IQ_W-1:0] shift_sat(
      input logic signed [2*radio_pkg::IQ_W-1:0] prod
   );
      logic signed [2*radio_pkg::IQ_W-1:0] shifted;
      logic [radio_pkg::IQ_W:0]            top;
      shifted = prod >>> radio_pkg::SCALE_FRAC;
      top     = shifted[2*radio_pkg::IQ_W-1:radio_pkg::IQ_W-1];
      if (&top || ~|top) begin
         shift_sat = shifted[radio_pkg::IQ_W-1:0];  // fits
      end else if (shifted[2*radio_pkg::IQ_W-1]) begin
         shift_sat = {1'b1, {(radio_pkg::IQ_W-1){1'b0}}};
      end else begin
         shift_sat = {1'b0, {(radio_pkg::IQ_W-1){1'b1}}};
      end
   endfunction

   // --------------------
   // stage 1 products
   always_ff @(posedge radio_clk) begin
      prod_i <= i_sample.iq.i * i_scale;
      prod_q <= i_sample.iq.q * i_scale;
   end

   // --------------------
   // stage 2 shift and saturate
   always_ff @(posedge radio_clk) begin
      o_bb_sample.iq.i <= shift_sat(prod_i);
      o_bb_sample.iq.q <= shift_sat(prod_q);
   end

   // valid follows the data through both stages
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         prod_valid <= 1'b0;
         o_bb_valid <= 1'b0;
      end else begin
         prod_valid <= i_sample_stb & i_run_rx;  // only while rx runs
         o_bb_valid <= prod_valid;
      end
   end

endmodule

// File: logic/rx_channel_mux.sv
// --------------------
// receive output side
// delays the raw words to line up with the scaler output,
// fans each radio out to its two channels and registers the result
// a valid baseband word replaces the data on every channel
// --------------------
`timescale 1ns/1ps

module rx_channel_mux (
   input  logic                                              radio_clk,
   input  logic                                              i_rst_n,
   input  radio_pkg::iq_sample_u [radio_pkg::NUM_RADIOS-1:0] i_samples,
   input  logic [radio_pkg::NUM_RADIOS-1:0]                  i_stb,
   input  radio_pkg::iq_sample_u                             i_bb_sample,
   input  logic                                              i_bb_valid,
   output logic [radio_pkg::NUM_CHANNELS-1:0][radio_pkg::SAMPLE_W-1:0] o_rx_data,
   output logic [radio_pkg::NUM_CHANNELS-1:0]                o_rx_stb
);

   radio_pkg::iq_sample_u [radio_pkg::NUM_RADIOS-1:0] raw_q [radio_pkg::SCALER_LATENCY];
   logic [radio_pkg::NUM_RADIOS-1:0]                  stb_q [radio_pkg::SCALER_LATENCY];

   // --------------------
   // alignment delay matching the scaler depth
   always_ff @(posedge radio_clk) begin
      raw_q[0] <= i_samples;
      for (int s = 1; s < radio_pkg::SCALER_LATENCY; s++) begin
         raw_q[s] <= raw_q[s-1];
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int s = 0; s < radio_pkg::SCALER_LATENCY; s++) begin
            stb_q[s] <= '0;
         end
      end else begin
         stb_q[0] <= i_stb;
         for (int s = 1; s < radio_pkg::SCALER_LATENCY; s++) begin
            stb_q[s] <= stb_q[s-1];
         end
      end
   end

   // --------------------
   // fan out and select
   always_ff @(posedge radio_clk) begin
      for (int ch = 0; ch < radio_pkg::NUM_CHANNELS; ch++) begin
         o_rx_data[ch] <= i_bb_valid ? i_bb_sample.raw  // baseband wins
            : raw_q[radio_pkg::SCALER_LATENCY-1][ch / radio_pkg::CHANS_PER_RADIO].raw;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rx_stb <= '0;
      end else begin
         for (int ch = 0; ch < radio_pkg::NUM_CHANNELS; ch++) begin
            o_rx_stb[ch] <= stb_q[radio_pkg::SCALER_LATENCY-1][ch / radio_pkg::CHANS_PER_RADIO];
         end
      end
   end

endmodule

// File: logic/radio_core.sv
// --------------------
// radio clock side of the receive core
// capture -> tag scaler -> channel mux, four cycles end to end
// settings bus and readback go to the db settings bank
// --------------------
`timescale 1ns/1ps

module radio_core (
   input  logic                                     radio_clk,
   input  logic                                     i_rst_n,
   // radio sample words
   input  logic [radio_pkg::SAMPLE_W-1:0]           i_rx0,
   input  logic [radio_pkg::SAMPLE_W-1:0]           i_rx1,
   input  logic [radio_pkg::NUM_RADIOS-1:0]         i_rx_stb,
   // settings and readback
   input  logic                                     i_set_stb,
   input  logic [settings_pkg::ADDR_W-1:0]          i_set_addr,
   input  logic [settings_pkg::DATA_W-1:0]          i_set_data,
   input  logic                                     i_rb_stb,
   input  logic [settings_pkg::ADDR_W-1:0]          i_rb_addr,
   output logic                                     o_rb_stb,
   output logic [settings_pkg::DATA_W-1:0]          o_rb_data,
   // misc pins
   input  logic [settings_pkg::DATA_W-1:0]          i_radio0_misc_in,
   input  logic [settings_pkg::DATA_W-1:0]          i_radio1_misc_in,
   output logic [settings_pkg::DATA_W-1:0]          o_radio0_misc_out,
   output logic [settings_pkg::DATA_W-1:0]          o_radio1_misc_out,
   // receive channels
   output logic [radio_pkg::NUM_CHANNELS-1:0][radio_pkg::SAMPLE_W-1:0] o_rx_data,
   output logic [radio_pkg::NUM_CHANNELS-1:0]       o_rx_stb
);

   radio_pkg::iq_sample_u [radio_pkg::NUM_RADIOS-1:0] cap_samples;
   logic [radio_pkg::NUM_RADIOS-1:0]                  cap_stb;
   logic [radio_pkg::IQ_W-1:0]                        scale;
   logic                                              run_rx;
   radio_pkg::iq_sample_u                             bb_sample;
   logic                                              bb_valid;

   radio_rx_capture radio_rx_capture_i (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_rx0(i_rx0), .i_rx1(i_rx1), .i_rx_stb(i_rx_stb),
      .o_samples(cap_samples), .o_stb(cap_stb)
   );

   db_settings db_settings_i (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_rb_stb(i_rb_stb), .i_rb_addr(i_rb_addr),
      .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
      .i_radio0_misc_in(i_radio0_misc_in), .i_radio1_misc_in(i_radio1_misc_in),
      .o_radio0_misc_out(o_radio0_misc_out), .o_radio1_misc_out(o_radio1_misc_out),
      .o_scale(scale), .o_run_rx(run_rx)
   );

   // tag path only sees the baseband radio
   tag_rx_scaler tag_rx_scaler_i (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_sample(cap_samples[radio_pkg::BB_RADIO]),
      .i_sample_stb(cap_stb[radio_pkg::BB_RADIO]),
      .i_run_rx(run_rx), .i_scale(scale),
      .o_bb_sample(bb_sample), .o_bb_valid(bb_valid)
   );

   rx_channel_mux rx_channel_mux_i (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_samples(cap_samples), .i_stb(cap_stb),
      .i_bb_sample(bb_sample), .i_bb_valid(bb_valid),
      .o_rx_data(o_rx_data), .o_rx_stb(o_rx_stb)
   );

endmodule

// File: tests/radio_core_sva.sv
// --------------------
// assertions bound into radio_core
// channel strobe pairing, readback strobe timing
// and quiet channel strobes right after reset
// --------------------
`timescale 1ns/1ps

module radio_core_sva (
   input logic                                radio_clk,
   input logic                                i_rst_n,
   input logic                                i_rb_stb,
   input logic                                o_rb_stb,
   input logic [radio_pkg::NUM_CHANNELS-1:0]  o_rx_stb
);

   // both channels of one radio strobe together
   a_chan_pairs: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      (o_rx_stb[0] == o_rx_stb[1]) && (o_rx_stb[2] == o_rx_stb[3]))
      else $error("channel strobes of one radio differ");

   // readback answers exactly one cycle after the request
   a_rb_timing: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb_stb == $past(i_rb_stb))
      else $error("o_rb_stb not one cycle after i_rb_stb");

   a_reset_quiet: assert property (@(posedge radio_clk)
      !i_rst_n |=> (o_rx_stb == '0))
      else $error("channel strobe high after reset");

endmodule

bind radio_core radio_core_sva radio_core_sva_i (.*);

// File: tests/radio_core_tb.sv
// --------------------
// testbench for radio_core
// random radio samples with and without the baseband path,
// settings writes and readback, every channel word checked
// against a model of the scaling rule and the 4 cycle latency
// --------------------
`timescale 1ns/1ps

module radio_core_tb;

   logic             radio_clk;
   logic             i_rst_n;
   logic [31:0]      i_rx0;
   logic [31:0]      i_rx1;
   logic [1:0]       i_rx_stb;
   logic             i_set_stb;
   logic [7:0]       i_set_addr;
   logic [31:0]      i_set_data;
   logic             i_rb_stb;
   logic [7:0]       i_rb_addr;
   logic [31:0]      i_radio0_misc_in;
   logic [31:0]      i_radio1_misc_in;
   logic             o_rb_stb;
   logic [31:0]      o_rb_data;
   logic [31:0]      o_radio0_misc_out;
   logic [31:0]      o_radio1_misc_out;
   logic [3:0][31:0] o_rx_data;
   logic [3:0]       o_rx_stb;

   logic [31:0] exp_q [4][$];  // expected words per channel
   int          exp_t [4][$];  // cycle each word is due
   int          cycle;
   int          errors;
   int          checks;
   int          tests;
   logic        run_rx;        // model copy of the run flag
   logic [15:0] scale;         // model copy of the scale

   radio_core radio_core_i (.*);

   always #50 radio_clk = ~radio_clk;

   always @(posedge radio_clk) cycle++;

   // one component as product >>> 15 clamped to 16 bits
   function automatic logic [15:0] scale_ref(input logic signed [15:0] comp,
                                             input logic signed [15:0] s);
      int p;
      p = (int'(comp) * int'(s)) >>> 15;
      if (p > 32767) begin
         p = 32767;
      end else if (p < -32768) begin
         p = -32768;
      end
      return p[15:0];
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic next_drive();
      @(posedge radio_clk);
      #10;
   endtask

   // drive one cycle of samples and queue what each channel should show
   task automatic send_samples(input logic [31:0] rx0, input logic [31:0] rx1,
                               input logic [1:0] stb);
      logic [31:0] bb;
      bb = {scale_ref(rx0[31:16], scale), scale_ref(rx0[15:0], scale)};
      i_rx0    = rx0;
      i_rx1    = rx1;
      i_rx_stb = stb;
      for (int ch = 0; ch < 4; ch++) begin
         if (stb[ch / 2]) begin
            exp_q[ch].push_back((run_rx && stb[0]) ? bb : (ch < 2 ? rx0 : rx1));
            exp_t[ch].push_back(cycle + 4);
         end
      end
      next_drive();
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()
              + exp_q[3].size()) != 0 && n < 20) begin
         next_drive();
         n++;
      end
      if ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()
           + exp_q[3].size()) != 0) begin
         errors++;
         $display("timeout: %s, channel strobes never arrived", what);
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      next_drive();
      i_set_stb  = 1'b0;
   endtask

   task automatic read_back(input logic [7:0] addr, output logic [31:0] data);
      int n;
      i_rb_stb  = 1'b1;
      i_rb_addr = addr;
      next_drive();
      i_rb_stb  = 1'b0;
      n = 0;
      while (o_rb_stb !== 1'b1 && n < 8) begin
         @(negedge radio_clk);
         n++;
      end
      if (o_rb_stb !== 1'b1) begin
         errors++;
         $display("timeout: no readback strobe for address %0d", addr);
      end
      data = o_rb_data;
      next_drive();
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   // --------------------
   // compare process
   always @(negedge radio_clk) begin
      if (i_rst_n) begin
         for (int ch = 0; ch < 4; ch++) begin
            if (o_rx_stb[ch] && exp_q[ch].size() == 0) begin
               errors++;
               $display("channel %0d strobed at %0t ns with no sample expected", ch, $time);
            end else if (o_rx_stb[ch]) begin
               check_value(o_rx_data[ch], exp_q[ch].pop_front(),
                           $sformatf("channel %0d data", ch));
               check_value(cycle, exp_t[ch].pop_front(), $sformatf("channel %0d cycle", ch));
            end
         end
      end
   end

   // --------------------
   // stimulus
   initial begin
      int          e;
      logic [31:0] rb;
      logic [31:0] val;
      void'($urandom(32'h6a5));
      radio_clk = 1'b0;
      i_rst_n = 1'b0;
      i_rx0 = '0;
      i_rx1 = '0;
      i_rx_stb = '0;
      i_set_stb = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rb_stb = 1'b0;
      i_rb_addr = '0;
      i_radio0_misc_in = '0;
      i_radio1_misc_in = '0;
      cycle = 0;
      errors = 0;
      checks = 0;
      tests = 0;
      run_rx = 1'b0;
      scale = '0;
      repeat (5) @(posedge radio_clk);
      #10;
      i_rst_n = 1'b1;

      e = errors;
      @(negedge radio_clk);
      check_value(o_rx_stb, 0, "strobes after reset");
      check_value(o_radio0_misc_out, 0, "misc out 0 after reset");
      check_value(o_radio1_misc_out, 0, "misc out 1 after reset");
      next_drive();
      read_back(settings_pkg::RB_SCALE, rb);
      check_value(rb, 0, "scale readback after reset");
      finish_test("reset", e);

      e = errors;
      for (int k = 0; k < 40; k++) begin
         send_samples($urandom, $urandom, 2'($urandom));
      end
      i_rx_stb = '0;
      wait_drain("raw passthrough");
      finish_test("raw passthrough", e);

      e = errors;
      scale = 16'($urandom);
      write_setting(settings_pkg::SR_SCALE, {16'h0, scale});
      write_setting(settings_pkg::SR_RUN_RX, 32'h1);
      run_rx = 1'b1;
      for (int k = 0; k < 40; k++) begin
         send_samples($urandom, $urandom, 2'($urandom));
      end
      i_rx_stb = '0;
      wait_drain("baseband");
      finish_test("baseband", e);

      e = errors;
      scale = 16'h8000;  // -1.0
      write_setting(settings_pkg::SR_SCALE, {16'h0, scale});
      send_samples(32'h8000_8000, $urandom, 2'b11);
      i_rx_stb = '0;
      wait_drain("saturation");
      scale = 16'h4000;  // 0.5
      write_setting(settings_pkg::SR_SCALE, {16'h0, scale});
      send_samples(32'h1234_0000, $urandom, 2'b01);
      send_samples(32'hedcc_0000, $urandom, 2'b11);
      i_rx_stb = '0;
      wait_drain("half scale");
      finish_test("saturation", e);

      e = errors;
      val = $urandom;
      write_setting(settings_pkg::SR_MISC_OUT0, val);
      check_value(o_radio0_misc_out, val, "misc out 0");
      val = $urandom;
      write_setting(settings_pkg::SR_MISC_OUT1, val);
      check_value(o_radio1_misc_out, val, "misc out 1");
      i_radio0_misc_in = $urandom;
      i_radio1_misc_in = $urandom;
      next_drive();
      read_back(settings_pkg::RB_MISC_IN0, rb);
      check_value(rb, i_radio0_misc_in, "misc in 0 readback");
      read_back(settings_pkg::RB_MISC_IN1, rb);
      check_value(rb, i_radio1_misc_in, "misc in 1 readback");
      read_back(settings_pkg::RB_SCALE, rb);
      check_value(rb, {16'h0, scale}, "scale readback");
      read_back(8'h55, rb);  // nothing mapped here
      check_value(rb, 0, "unknown address readback");
      finish_test("settings and readback", e);

      repeat (3) next_drive();  // let any stray strobe show up
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: radio_core.f
common/radio_pkg.sv
common/settings_pkg.sv
logic/radio_rx_capture.sv
db_settings/db_settings.sv
tag_rx/tag_rx_scaler.sv
logic/rx_channel_mux.sv
logic/radio_core.sv
tests/radio_core_sva.sv
tests/radio_core_tb.sv

// File: Bender.yml
package:
  name: radio_core

sources:
  # shared packages
  - common/radio_pkg.sv
  - common/settings_pkg.sv
  # rtl
  - logic/radio_rx_capture.sv
  - db_settings/db_settings.sv
  - tag_rx/tag_rx_scaler.sv
  - logic/rx_channel_mux.sv
  - logic/radio_core.sv
  # testbench and bound assertions
  - target: test
    files:
      - tests/radio_core_sva.sv
      - tests/radio_core_tb.sv
